// ==== flist.f ====
+incdir+test
hdl/bitmanip_pkg.sv
hdl/bitmanip_decode.sv
hdl/stage_reg.sv
hdl/bitmanip_count.sv
hdl/clmul_unit.sv
hdl/bitmanip_exec.sv
hdl/rv32b_execute.sv
test/rv32b_execute_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv32b_execute testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f flist.f --top-module rv32b_execute_tb -o rv32b_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/rv32b_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Result: FAILED" "$log"; then
   exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "Result: PASSED" "$log"; then
   echo "Simulation did not complete"
   exit 1
fi
exit 0

// ==== test/rv32b_ref_model.svh ====
// Encoders and reference model
`ifndef RV32B_REF_MODEL_SVH
`define RV32B_REF_MODEL_SVH

// R-type with rd x3, rs1 x1, rs2 x2
function automatic xlen_t enc_r(logic [6:0] f7, logic [2:0] f3);
   return {f7, 5'd2, 5'd1, f3, 5'd3, opcode_op};
endfunction

// Unary I-type, fixed upper immediate
function automatic xlen_t enc_u(logic [11:0] f12, logic [2:0] f3);
   return {f12, 5'd1, f3, 5'd3, opcode_op_imm};
endfunction

//////////////////////////////////////////////////
// Instruction word per operation
//////////////////////////////////////////////////

function automatic xlen_t enc_op(b_op_e op);
   case (op)
      op_andn:   return enc_r(funct7_logic_neg, 3'b111);
      op_orn:    return enc_r(funct7_logic_neg, 3'b110);
      op_xnor:   return enc_r(funct7_logic_neg, 3'b100);
      op_max:    return enc_r(funct7_minmax_clmul, 3'b110);
      op_maxu:   return enc_r(funct7_minmax_clmul, 3'b111);
      op_min:    return enc_r(funct7_minmax_clmul, 3'b100);
      op_minu:   return enc_r(funct7_minmax_clmul, 3'b101);
      op_rol:    return enc_r(funct7_rotate, 3'b001);
      op_ror:    return enc_r(funct7_rotate, 3'b101);
      op_sh1add: return enc_r(funct7_shadd, 3'b010);
      op_sh2add: return enc_r(funct7_shadd, 3'b100);
      op_sh3add: return enc_r(funct7_shadd, 3'b110);
      op_bclr:   return enc_r(funct7_bclr_bext, 3'b001);
      op_bext:   return enc_r(funct7_bclr_bext, 3'b101);
      op_binv:   return enc_r(funct7_binv, 3'b001);
      op_bset:   return enc_r(funct7_bset, 3'b001);
      op_clmul:  return enc_r(funct7_minmax_clmul, 3'b001);
      op_clmulh: return enc_r(funct7_minmax_clmul, 3'b011);
      op_clmulr: return enc_r(funct7_minmax_clmul, 3'b010);
      op_clz:    return enc_u(funct12_clz, 3'b001);
      op_ctz:    return enc_u(funct12_ctz, 3'b001);
      op_cpop:   return enc_u(funct12_cpop, 3'b001);
      op_orc_b:  return enc_u(funct12_orc_b, 3'b101);
      op_rev8:   return enc_u(funct12_rev8, 3'b101);
      op_sext_b: return enc_u(funct12_sext_b, 3'b001);
      op_sext_h: return enc_u(funct12_sext_h, 3'b001);
      // zext.h needs a zero rs2 field
      op_zext_h: return {funct7_zext, 5'd0, 5'd1, 3'b100, 5'd3, opcode_op};
      default:   return '0;
   endcase
endfunction

// Immediate form, same funct7 and funct3 as the register form
function automatic xlen_t enc_imm(b_op_e op, logic [4:0] shamt);
   xlen_t w;
   w        = enc_op(op);
   w[24:20] = shamt;
   w[6:0]   = opcode_op_imm;
   return w;
endfunction

// 32-bit LCG step
function automatic xlen_t lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

//////////////////////////////////////////////////
// Expected results, ratified rules
//////////////////////////////////////////////////

function automatic xlen_t exp_result(b_op_e op, xlen_t a, xlen_t b);
   logic [63:0] p;
   xlen_t       lz;
   xlen_t       tz;
   xlen_t       orc;
   int          n;
   n  = int'(b[4:0]);
   p  = '0;
   lz = 32;
   tz = 32;
   // Zero counts from both ends, product built from the bits of a
   for (int i = 0; i < 32; i++) begin
      if (a[31-i] && lz == 32)
         lz = i;
      if (a[i] && tz == 32)
         tz = i;
      if (a[i])
         p = p ^ (64'(b) << i);
   end
   for (int k = 0; k < 4; k++)
      orc[8*k +: 8] = (a[8*k +: 8] != 8'd0) ? 8'hff : 8'h00;
   case (op)
      op_andn:   return a & ~b;
      op_orn:    return a | ~b;
      op_xnor:   return a ~^ b;
      op_max:    return ($signed(a) > $signed(b)) ? a : b;
      op_maxu:   return (a > b) ? a : b;
      op_min:    return ($signed(a) < $signed(b)) ? a : b;
      op_minu:   return (a < b) ? a : b;
      op_rol:    return (n == 0) ? a : ((a << n) | (a >> (32 - n)));
      op_ror:    return (n == 0) ? a : ((a >> n) | (a << (32 - n)));
      op_sh1add: return b + a * 2;
      op_sh2add: return b + a * 4;
      op_sh3add: return b + a * 8;
      op_bclr:   return a & ~(32'd1 << n);
      op_bext:   return {31'd0, a[n]};
      op_binv:   return a ^ (32'd1 << n);
      op_bset:   return a | (32'd1 << n);
      op_clmul:  return p[31:0];
      op_clmulh: return p[63:32];
      op_clmulr: return p[62:31];
      op_clz:    return lz;
      op_ctz:    return tz;
      op_cpop:   return 32'($countones(a));
      op_orc_b:  return orc;
      op_rev8:   return {a[7:0], a[15:8], a[23:16], a[31:24]};
      op_sext_b: return xlen_t'(signed'(a[7:0]));
      op_sext_h: return xlen_t'(signed'(a[15:0]));
      op_zext_h: return {16'd0, a[15:0]};
      default:   return '0;
   endcase
endfunction

`endif

// ==== test/rv32b_execute_tb.sv ====
// RV32 bit-manipulation execute testbench
`timescale 1ns/100ps

module rv32b_execute_tb;
   import bitmanip_pkg::*;

   localparam int timeout_cycles = 20;

   logic  CLK;
   logic  reset;
   logic  valid_cmd;
   xlen_t instr;
   xlen_t rs1_val;
   xlen_t rs2_val;
   logic  valid;
   xlen_t rv32b_out;

   // LCG state, fixed seed
   int unsigned lcg_state = 63628;

   `include "rv32b_ref_model.svh"

   rv32b_execute i_rv32b_execute (
      .CLK       (CLK),
      .reset     (reset),
      .valid_cmd (valid_cmd),
      .instr     (instr),
      .rs1_val   (rs1_val),
      .rs2_val   (rs2_val),
      .valid     (valid),
      .rv32b_out (rv32b_out)
   );

   // 100 ns clock
   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   //////////////////////////////////////////////////
   // Check and stop
   //////////////////////////////////////////////////

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(xlen_t actual, xlen_t expected, string what);
      if (actual !== expected) begin
         $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
         abort_run();
      end
   endtask

   task automatic timeout_stop(string what);
      $display("Timeout: no valid result for %s within %0d cycles", what, timeout_cycles);
      abort_run();
   endtask

   //////////////////////////////////////////////////
   // Command driving
   //////////////////////////////////////////////////

   task automatic drive_cmd(xlen_t cmd, xlen_t a, xlen_t b);
      valid_cmd <= 1'b1;
      instr     <= cmd;
      rs1_val   <= a;
      rs2_val   <= b;
   endtask

   // One command, result expected two edges after the DUT takes it
   task automatic run_cmd(xlen_t cmd, xlen_t a, xlen_t b, xlen_t expected, string what);
      int cycles;
      @(posedge CLK);
      drive_cmd(cmd, a, b);
      @(posedge CLK);
      valid_cmd <= 1'b0;
      cycles = 0;
      do begin
         @(posedge CLK);
         cycles++;
         if (cycles > timeout_cycles)
            timeout_stop(what);
      end while (!valid);
      check_value(xlen_t'(cycles), 32'd2, {what, " latency"});
      check_value(rv32b_out, expected, what);
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic test_reset();
      // First edge still shows the unreset flop
      for (int i = 0; i < 8; i++) begin
         @(posedge CLK);
         if (i > 0)
            check_value(xlen_t'(valid), '0, "valid during reset");
      end
      reset <= 1'b0;
      for (int i = 0; i < 4; i++) begin
         @(posedge CLK);
         check_value(xlen_t'(valid), '0, "valid after reset");
      end
   endtask

   task automatic test_reg_reg();
      b_op_e ops[16] = '{op_andn, op_orn, op_xnor, op_max, op_maxu, op_min, op_minu, op_rol,
                         op_ror, op_sh1add, op_sh2add, op_sh3add, op_bclr, op_bext, op_binv,
                         op_bset};
      xlen_t edges[3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
      xlen_t a;
      xlen_t b;
      foreach (ops[i]) begin
         for (int n = 0; n < 4; n++) begin
            a = lcg_next();
            b = lcg_next();
            run_cmd(enc_op(ops[i]), a, b, exp_result(ops[i], a, b), ops[i].name());
         end
      end
      // Min and max, every pair of edge values
      for (int i = 3; i < 7; i++) begin
         for (int m = 0; m < 9; m++) begin
            a = edges[m / 3];
            b = edges[m % 3];
            run_cmd(enc_op(ops[i]), a, b, exp_result(ops[i], a, b), ops[i].name());
         end
      end
   endtask

   task automatic test_imm();
      b_op_e      ops[5]    = '{op_ror, op_bclr, op_bext, op_binv, op_bset};
      logic [4:0] shamts[5] = '{5'd0, 5'd1, 5'd7, 5'd16, 5'd31};
      xlen_t      a;
      foreach (ops[i]) begin
         foreach (shamts[s]) begin
            a = lcg_next();
            // rs2 noise, ignored by the immediate form
            run_cmd(enc_imm(ops[i], shamts[s]), a, lcg_next(),
                    exp_result(ops[i], a, xlen_t'(shamts[s])), {ops[i].name(), "i"});
         end
      end
   endtask

   task automatic test_unary();
      b_op_e ops[8] = '{op_clz, op_ctz, op_cpop, op_orc_b, op_rev8, op_sext_b, op_sext_h,
                        op_zext_h};
      xlen_t vals[6];
      xlen_t r;
      foreach (ops[i]) begin
         r    = lcg_next();
         vals = '{32'h0, 32'hffff_ffff, 32'd1 << r[4:0], 32'h0001_8f80, lcg_next(), lcg_next()};
         foreach (vals[v])
            run_cmd(enc_op(ops[i]), vals[v], lcg_next(),
                    exp_result(ops[i], vals[v], '0), ops[i].name());
      end
   endtask

   task automatic test_clmul();
      b_op_e ops[3] = '{op_clmul, op_clmulh, op_clmulr};
      xlen_t a;
      xlen_t b;
      foreach (ops[i]) begin
         for (int n = 0; n < 6; n++) begin
            // Last pass all ones, widest product
            a = (n == 5) ? 32'hffff_ffff : lcg_next();
            b = (n == 5) ? 32'hffff_ffff : lcg_next();
            run_cmd(enc_op(ops[i]), a, b, exp_result(ops[i], a, b), ops[i].name());
         end
      end
   endtask

   task automatic test_stream_reject();
      b_op_e stream_ops[8] = '{op_andn, op_rol, op_sh2add, op_bset, op_clmul, op_clz, op_rev8,
                               op_max};
      xlen_t exp_q[$];
      xlen_t a;
      xlen_t b;
      xlen_t rej;
      int    got;
      int    first;
      int    cyc;
      got   = 0;
      first = 0;
      cyc   = 0;
      // Drive on edges 1 to 8, collect as results appear
      while (got < 8) begin
         @(posedge CLK);
         cyc++;
         if (cyc > 8 + timeout_cycles)
            timeout_stop("back-to-back run");
         if (valid) begin
            if (first == 0)
               first = cyc;
            check_value(xlen_t'(cyc - first), xlen_t'(got), "back-to-back spacing");
            check_value(rv32b_out, exp_q.pop_front(), "back-to-back result");
            got++;
         end
         if (cyc <= 8) begin
            a = lcg_next();
            b = lcg_next();
            drive_cmd(enc_op(stream_ops[cyc-1]), a, b);
            exp_q.push_back(exp_result(stream_ops[cyc-1], a, b));
         end else begin
            valid_cmd <= 1'b0;
         end
      end
      check_value(xlen_t'(first), 32'd4, "back-to-back first result edge");
      // andn fields under the RV64 word opcode
      rej      = enc_op(op_andn);
      rej[6:0] = 7'b011_1011;
      @(posedge CLK);
      drive_cmd(rej, lcg_next(), lcg_next());
      @(posedge CLK);
      valid_cmd <= 1'b0;
      for (int i = 0; i < 5; i++) begin
         @(posedge CLK);
         check_value(xlen_t'(valid), '0, "valid after rejected command");
      end
      a = lcg_next();
      b = lcg_next();
      run_cmd(enc_op(op_xnor), a, b, exp_result(op_xnor, a, b), "xnor after reject");
   endtask

   initial begin
      reset     = 1'b1;
      valid_cmd = 1'b0;
      instr     = '0;
      rs1_val   = '0;
      rs2_val   = '0;
      test_reset();
      test_reg_reg();
      test_imm();
      test_unary();
      test_clmul();
      test_stream_reject();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== hdl/rv32b_execute.sv ====
// RV32 bit-manipulation execute stage
`timescale 1ns/100ps

module rv32b_execute (
   input  logic                CLK,
   input  logic                reset,
   input  logic                valid_cmd,
   input  bitmanip_pkg::xlen_t instr,
   input  bitmanip_pkg::xlen_t rs1_val,
   input  bitmanip_pkg::xlen_t rs2_val,
   output logic                valid,
   output bitmanip_pkg::xlen_t rv32b_out
);
   import bitmanip_pkg::*;

   // Decode to operation register
   logic  dec_valid;
   b_op_t dec_op;

   // Operation register to execute
   logic  ex_valid;
   b_op_t ex_op;
   xlen_t ex_result;

   bitmanip_decode i_decode (
      .valid_cmd (valid_cmd),
      .instr     (instr),
      .rs1_val   (rs1_val),
      .rs2_val   (rs2_val),
      .op_valid  (dec_valid),
      .op        (dec_op)
   );

   // Stage 1, decoded operation
   stage_reg #(.payload_t(b_op_t)) i_op_reg (
      .CLK       (CLK),
      .reset     (reset),
      .in_valid  (dec_valid),
      .in_data   (dec_op),
      .out_valid (ex_valid),
      .out_data  (ex_op)
   );

   bitmanip_exec i_exec (
      .op     (ex_op),
      .result (ex_result)
   );

   // Stage 2, result to the outputs
   stage_reg #(.payload_t(xlen_t)) i_res_reg (
      .CLK       (CLK),
      .reset     (reset),
      .in_valid  (ex_valid),
      .in_data   (ex_result),
      .out_valid (valid),
      .out_data  (rv32b_out)
   );

endmodule

// ==== hdl/bitmanip_exec.sv ====
// Bit-manipulation execute datapath
`timescale 1ns/100ps

module bitmanip_exec (
   input  bitmanip_pkg::b_op_t op,
   output bitmanip_pkg::xlen_t result
);
   import bitmanip_pkg::*;

   logic [shamt_w-1:0] sh;         // b mod 32
   logic [2*xlen-1:0]  rot_r;
   logic [2*xlen-1:0]  rot_l;
   xlen_t              bit_mask;
   logic               lt_s;
   logic               lt_u;
   xlen_t              count_result;
   clmul_prod_t        prod;

   //////////////////////////////////////////////////
   // Shared terms
   //////////////////////////////////////////////////

   assign sh = op.b[shamt_w-1:0];

   // Rotate through a doubled word
   assign rot_r = {op.a, op.a} >> sh;
   assign rot_l = {op.a, op.a} << sh;

   // Single-bit mask
   assign bit_mask = xlen_t'(1) << sh;

   // Compares for min and max
   assign lt_s = $signed(op.a) < $signed(op.b);
   assign lt_u = op.a < op.b;

   //////////////////////////////////////////////////
   // Units on the same operands
   //////////////////////////////////////////////////

   bitmanip_count i_count (
      .op     (op.op),
      .a      (op.a),
      .result (count_result)
   );

   clmul_unit i_clmul (
      .a       (op.a),
      .b       (op.b),
      .product (prod)
   );

   //////////////////////////////////////////////////
   // Result select
   //////////////////////////////////////////////////

   always_comb begin
      case (op.op)
         op_andn:   result = op.a & ~op.b;
         op_orn:    result = op.a | ~op.b;
         op_xnor:   result = ~(op.a ^ op.b);
         op_max:    result = lt_s ? op.b : op.a;
         op_maxu:   result = lt_u ? op.b : op.a;
         op_min:    result = lt_s ? op.a : op.b;
         op_minu:   result = lt_u ? op.a : op.b;
         op_rol:    result = rot_l[2*xlen-1:xlen];
         op_ror:    result = rot_r[xlen-1:0];
         // Shift-add, a scaled onto b
         op_sh1add: result = op.b + (op.a << 1);
         op_sh2add: result = op.b + (op.a << 2);
         op_sh3add: result = op.b + (op.a << 3);
         op_bclr:   result = op.a & ~bit_mask;
         op_bext:   result = xlen_t'(op.a[sh]);
         op_binv:   result = op.a ^ bit_mask;
         op_bset:   result = op.a | bit_mask;
         // Product slices
         op_clmul:  result = prod[xlen-1:0];
         op_clmulh: result = prod[2*xlen-1:xlen];
         op_clmulr: result = prod[2*xlen-2:xlen-1];
         op_clz, op_ctz, op_cpop, op_orc_b, op_rev8,
         op_sext_b, op_sext_h, op_zext_h:
                    result = count_result;
         default:   result = '0;
      endcase
   end

   // Registered op holds only decoder codes, X before first load
   assert final ($isunknown(op.op) || op.op <= op_zext_h)
      else $error("unknown operation code %0d", op.op);

endmodule

// ==== hdl/clmul_unit.sv ====
// Carry-less multiplier
`timescale 1ns/100ps

module clmul_unit (
   input  bitmanip_pkg::xlen_t       a,
   input  bitmanip_pkg::xlen_t       b,
   output bitmanip_pkg::clmul_prod_t product
);
   import bitmanip_pkg::*;

   // One partial product per bit of b
   clmul_prod_t pp [xlen];

   //////////////////////////////////////////////////
   // Partial products
   //////////////////////////////////////////////////

   for (genvar i = 0; i < xlen; i++) begin : g_pp
      // a shifted by i where b[i] is set
      assign pp[i] = b[i] ? (clmul_prod_t'(a) << i) : '0;
   end

   //////////////////////////////////////////////////
   // XOR reduction
   //////////////////////////////////////////////////

   // Full 64-bit product, callers take their slice
   always_comb begin
      product = '0;
      for (int i = 0; i < xlen; i++) begin
         product = product ^ pp[i];
      end
   end

endmodule

// ==== hdl/bitmanip_count.sv ====
// Count, byte and extension unit
`timescale 1ns/100ps

module bitmanip_count (
   input  bitmanip_pkg::b_op_e op,
   input  bitmanip_pkg::xlen_t a,
   output bitmanip_pkg::xlen_t result
);
   import bitmanip_pkg::*;

   // Counts reach xlen, one bit wider than a shift amount
   typedef logic [shamt_w:0] count_t;

   count_t lead_zeros;
   count_t trail_zeros;
   count_t ones;
   xlen_t  orc_b;
   xlen_t  rev8;

   //////////////////////////////////////////////////
   // Zero and population counts
   //////////////////////////////////////////////////

   always_comb begin
      // All-zero input leaves both counts at xlen
      lead_zeros  = count_t'(xlen);
      trail_zeros = count_t'(xlen);
      ones        = '0;
      for (int i = 0; i < xlen; i++) begin
         // Last hit wins, highest set bit
         if (a[i]) begin
            lead_zeros = count_t'(xlen - 1 - i);
         end
         // Scanning down, lowest set bit wins
         if (a[xlen-1-i]) begin
            trail_zeros = count_t'(xlen - 1 - i);
         end
         ones = ones + count_t'(a[i]);
      end
   end

   // Per-byte OR-combine and byte reversal
   for (genvar k = 0; k < xlen/8; k++) begin : g_byte
      assign orc_b[8*k +: 8] = {8{|a[8*k +: 8]}};
      assign rev8[8*k +: 8]  = a[xlen-8-8*k +: 8];
   end

   //////////////////////////////////////////////////
   // Result select
   //////////////////////////////////////////////////

   always_comb begin
      case (op)
         op_clz:    result = xlen_t'(lead_zeros);
         op_ctz:    result = xlen_t'(trail_zeros);
         op_cpop:   result = xlen_t'(ones);
         op_orc_b:  result = orc_b;
         op_rev8:   result = rev8;
         op_sext_b: result = {{(xlen-8){a[7]}}, a[7:0]};
         op_sext_h: result = {{(xlen-16){a[15]}}, a[15:0]};
         op_zext_h: result = {{(xlen-16){1'b0}}, a[15:0]};
         default:   result = '0;   // Not a unary op
      endcase
   end

endmodule

// ==== hdl/stage_reg.sv ====
// Valid and payload pipeline register
`timescale 1ns/100ps

module stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     CLK,
   input  logic     reset,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   // Valid bit, follows input every cycle
   always_ff @(posedge CLK) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   // Payload, loads only with a valid input
   always_ff @(posedge CLK) begin
      if (in_valid) begin
         out_data <= in_data;
      end
   end

   // A valid stage output carries a fully known payload
   assert property (@(posedge CLK) disable iff (reset) out_valid |-> !$isunknown(out_data))
      else $error("valid payload has unknown bits");

endmodule

// ==== hdl/bitmanip_decode.sv ====
// Bit-manipulation decoder
`timescale 1ns/100ps

module bitmanip_decode (
   input  logic                valid_cmd,
   input  bitmanip_pkg::xlen_t instr,
   input  bitmanip_pkg::xlen_t rs1_val,
   input  bitmanip_pkg::xlen_t rs2_val,
   output logic                op_valid,
   output bitmanip_pkg::b_op_t op
);
   import bitmanip_pkg::*;

   // Instruction fields
   logic [6:0]         opcode;
   logic [2:0]         funct3;
   logic [6:0]         funct7;
   logic [11:0]        funct12;
   logic [shamt_w-1:0] shamt;

   logic op_known;     // Encoding recognized
   logic imm_form;     // Operand b from the shift field

   assign opcode  = instr[6:0];
   assign funct3  = instr[14:12];
   assign funct7  = instr[31:25];
   assign funct12 = instr[31:20];
   assign shamt   = instr[24:20];   // Also the rs2 field

   //////////////////////////////////////////////////
   // Operation select
   //////////////////////////////////////////////////

   always_comb begin
      op_known = 1'b1;
      imm_form = 1'b0;
      op.op    = op_andn;
      if (opcode == opcode_op) begin
         case ({funct7, funct3})
            {funct7_logic_neg, 3'b111}:    op.op = op_andn;
            {funct7_logic_neg, 3'b110}:    op.op = op_orn;
            {funct7_logic_neg, 3'b100}:    op.op = op_xnor;
            {funct7_minmax_clmul, 3'b110}: op.op = op_max;
            {funct7_minmax_clmul, 3'b111}: op.op = op_maxu;
            {funct7_minmax_clmul, 3'b100}: op.op = op_min;
            {funct7_minmax_clmul, 3'b101}: op.op = op_minu;
            {funct7_minmax_clmul, 3'b001}: op.op = op_clmul;
            {funct7_minmax_clmul, 3'b011}: op.op = op_clmulh;
            {funct7_minmax_clmul, 3'b010}: op.op = op_clmulr;
            {funct7_rotate, 3'b001}:       op.op = op_rol;
            {funct7_rotate, 3'b101}:       op.op = op_ror;
            {funct7_shadd, 3'b010}:        op.op = op_sh1add;
            {funct7_shadd, 3'b100}:        op.op = op_sh2add;
            {funct7_shadd, 3'b110}:        op.op = op_sh3add;
            {funct7_bclr_bext, 3'b001}:    op.op = op_bclr;
            {funct7_bclr_bext, 3'b101}:    op.op = op_bext;
            {funct7_binv, 3'b001}:         op.op = op_binv;
            {funct7_bset, 3'b001}:         op.op = op_bset;
            {funct7_zext, 3'b100}: begin
               op.op    = op_zext_h;
               // rs2 field must be zero
               op_known = (shamt == '0);
            end
            default:                       op_known = 1'b0;
         endcase
      end else if (opcode == opcode_op_imm) begin
         imm_form = 1'b1;
         // Unary ops first, full upper immediate
         case ({funct12, funct3})
            {funct12_clz, 3'b001}:    op.op = op_clz;
            {funct12_ctz, 3'b001}:    op.op = op_ctz;
            {funct12_cpop, 3'b001}:   op.op = op_cpop;
            {funct12_sext_b, 3'b001}: op.op = op_sext_b;
            {funct12_sext_h, 3'b001}: op.op = op_sext_h;
            {funct12_orc_b, 3'b101}:  op.op = op_orc_b;
            {funct12_rev8, 3'b101}:   op.op = op_rev8;
            default: begin
               // Shift-immediate forms fold onto register forms
               case ({funct7, funct3})
                  {funct7_rotate, 3'b101}:    op.op = op_ror;
                  {funct7_bclr_bext, 3'b001}: op.op = op_bclr;
                  {funct7_bclr_bext, 3'b101}: op.op = op_bext;
                  {funct7_binv, 3'b001}:      op.op = op_binv;
                  {funct7_bset, 3'b001}:      op.op = op_bset;
                  default:                    op_known = 1'b0;
               endcase
            end
         endcase
      end else begin
         // Word forms and everything else
         op_known = 1'b0;
      end
      op.a = rs1_val;
      op.b = imm_form ? xlen_t'(shamt) : rs2_val;
   end

   assign op_valid = valid_cmd && op_known;

   // A command carries a known instruction word
   assert final (!valid_cmd || !$isunknown(instr))
      else $error("command with unknown instruction word");

endmodule

// ==== hdl/bitmanip_pkg.sv ====
// Bit-manipulation shared definitions
package bitmanip_pkg;

   //////////////////////////////////////////////////
   // Widths and data types
   //////////////////////////////////////////////////

   localparam int xlen    = 32;
   localparam int shamt_w = 5;    // log2(xlen)

   typedef logic [xlen-1:0]   xlen_t;
   typedef logic [2*xlen-1:0] clmul_prod_t;

   //////////////////////////////////////////////////
   // Instruction encodings
   //////////////////////////////////////////////////

   // Major opcodes
   localparam logic [6:0] opcode_op     = 7'b011_0011;
   localparam logic [6:0] opcode_op_imm = 7'b001_0011;

   // funct7 per family
   localparam logic [6:0] funct7_logic_neg    = 7'b010_0000;   // andn orn xnor
   localparam logic [6:0] funct7_minmax_clmul = 7'b000_0101;
   localparam logic [6:0] funct7_rotate       = 7'b011_0000;
   localparam logic [6:0] funct7_shadd        = 7'b001_0000;
   localparam logic [6:0] funct7_bclr_bext    = 7'b010_0100;
   localparam logic [6:0] funct7_binv         = 7'b011_0100;
   localparam logic [6:0] funct7_bset         = 7'b001_0100;
   localparam logic [6:0] funct7_zext         = 7'b000_0100;

   // Fixed upper immediates of the unary ops, RV32 patterns
   localparam logic [11:0] funct12_clz    = 12'b0110_0000_0000;
   localparam logic [11:0] funct12_ctz    = 12'b0110_0000_0001;
   localparam logic [11:0] funct12_cpop   = 12'b0110_0000_0010;
   localparam logic [11:0] funct12_sext_b = 12'b0110_0000_0100;
   localparam logic [11:0] funct12_sext_h = 12'b0110_0000_0101;
   localparam logic [11:0] funct12_orc_b  = 12'b0010_1000_0111;
   localparam logic [11:0] funct12_rev8   = 12'b0110_1001_1000;

   //////////////////////////////////////////////////
   // Decoded operation
   //////////////////////////////////////////////////

   // Immediate forms share the code of their register form
   typedef enum logic [4:0] {
      op_andn,
      op_orn,
      op_xnor,
      op_max,
      op_maxu,
      op_min,
      op_minu,
      op_rol,
      op_ror,
      op_sh1add,
      op_sh2add,
      op_sh3add,
      op_bclr,
      op_bext,
      op_binv,
      op_bset,
      op_clmul,
      op_clmulh,
      op_clmulr,
      op_clz,
      op_ctz,
      op_cpop,
      op_orc_b,
      op_rev8,
      op_sext_b,
      op_sext_h,
      op_zext_h
   } b_op_e;

   // Operation with both operands, 69 bits
   typedef struct packed {
      b_op_e op;
      xlen_t a;
      xlen_t b;
   } b_op_t;

endpackage
